/* Bender.yml */
package:
  name: raster

sources:
  # Design
  - files:
      - design/raster_pkg.sv
      - design/edge_walker.sv
      - design/tri_dispatch.sv
      - design/frag_arbiter.sv
      - design/raster_top.sv

  # Verification
  - target: test
    files:
      - verif/raster_chk.sv
      - verif/raster_tb.sv

/* design/edge_walker.sv */
`timescale 1ns/100ps
`default_nettype none

module edge_walker
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   tri_valid,
    input  wire raster_pkg::tri_s tri_data,
    output logic                  tri_ready,
    output logic                  frag_valid,
    output raster_pkg::bus_s      frag,
    input  wire                   frag_ready
);

    typedef enum logic [1:0] {S_IDLE, S_ROW, S_PIX} state_e;

    state_e     state;
    logic [1:0] setup_q;

    raster_pkg::tri_s    tri_q;
    raster_pkg::vertex_s vtx [3];

    logic signed [raster_pkg::EDGE_W-1:0] vx [3];
    logic signed [raster_pkg::EDGE_W-1:0] vy [3];
    logic signed [raster_pkg::EDGE_W-1:0] dx_q [3];
    logic signed [raster_pkg::EDGE_W-1:0] dy_q [3];
    logic signed [raster_pkg::EDGE_W-1:0] e_init [3];
    logic signed [raster_pkg::EDGE_W-1:0] e_row [3];
    logic signed [raster_pkg::EDGE_W-1:0] e_pix [3];
    logic signed [raster_pkg::EDGE_W-1:0] org_x;
    logic signed [raster_pkg::EDGE_W-1:0] org_y;
    logic signed [raster_pkg::EDGE_W-1:0] area;

    logic [raster_pkg::COL_LEN-1:0]  box_min_x;
    logic [raster_pkg::COL_LEN-1:0]  box_max_x;
    logic [raster_pkg::LINE_LEN-1:0] box_min_y;
    logic [raster_pkg::LINE_LEN-1:0] box_max_y;
    logic [raster_pkg::COL_LEN-1:0]  min_x_q;
    logic [raster_pkg::COL_LEN-1:0]  max_x_q;
    logic [raster_pkg::LINE_LEN-1:0] min_y_q;
    logic [raster_pkg::LINE_LEN-1:0] max_y_q;
    logic [raster_pkg::COL_LEN-1:0]  cur_x;
    logic [raster_pkg::LINE_LEN-1:0] cur_y;

    logic covered;
    logic step;

    //////////////////////////////////////////////////////////////////////
    // Vertex view, bounding box and corner edge values
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        vtx[0] = tri_q.v1;
        vtx[1] = tri_q.v2;
        vtx[2] = tri_q.v3;
        box_min_x = vtx[0].x;
        box_max_x = vtx[0].x;
        box_min_y = vtx[0].y;
        box_max_y = vtx[0].y;
        for (int i = 0; i < 3; i++)
        begin
            vx[i] = vtx[i].x;
            vy[i] = vtx[i].y;
            if (vtx[i].x < box_min_x)
                box_min_x = vtx[i].x;
            if (vtx[i].x > box_max_x)
                box_max_x = vtx[i].x;
            if (vtx[i].y < box_min_y)
                box_min_y = vtx[i].y;
            if (vtx[i].y > box_max_y)
                box_max_y = vtx[i].y;
        end
    end

    // Edge i runs from vertex i to vertex i+1; inside is non-negative
    always_comb
    begin
        org_x = min_x_q;
        org_y = min_y_q;
        for (int i = 0; i < 3; i++)
        begin
            e_init[i] = dy_q[i] * (org_x - vx[i]) - dx_q[i] * (org_y - vy[i]);
        end
        // Sum of the three edges is twice the signed area
        area = e_init[0] + e_init[1] + e_init[2];
    end

    assign covered = !e_pix[0][raster_pkg::EDGE_W-1] &&
                     !e_pix[1][raster_pkg::EDGE_W-1] &&
                     !e_pix[2][raster_pkg::EDGE_W-1];
    assign step = !covered || frag_ready;

    assign tri_ready  = (state == S_IDLE);
    assign frag_valid = (state == S_PIX) && covered;

    always_comb
    begin
        frag.is_marker       = 1'b0;
        frag.word.frag.tag   = tri_q.tag;
        frag.word.frag.y     = cur_y;
        frag.word.frag.x     = cur_x;
        frag.word.frag.color = tri_q.color;
        frag.word.frag.z     = tri_q.z;
    end

    //////////////////////////////////////////////////////////////////////
    // Scan control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= S_IDLE;
            setup_q <= 2'b00;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (tri_valid)
                    begin
                        state   <= S_ROW;
                        setup_q <= 2'b01;
                    end
                end
                S_ROW:
                begin
                    if (setup_q[0])
                        setup_q <= 2'b10;
                    else if (setup_q[1])
                    begin
                        setup_q <= 2'b00;
                        // Clockwise or degenerate
                        if (area <= 0)
                            state <= S_IDLE;
                    end
                    else if (cur_y > max_y_q)
                        state <= S_IDLE;
                    else
                        state <= S_PIX;
                end
                S_PIX:
                begin
                    if (step && cur_x == max_x_q)
                        state <= S_ROW;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // Triangle, box and edge accumulators
    always_ff @(posedge clk)
    begin
        case (state)
            S_IDLE:
            begin
                if (tri_valid)
                    tri_q <= tri_data;
            end
            S_ROW:
            begin
                if (setup_q[0])
                begin
                    min_x_q <= box_min_x;
                    max_x_q <= box_max_x;
                    min_y_q <= box_min_y;
                    max_y_q <= box_max_y;
                    for (int i = 0; i < 3; i++)
                    begin
                        dx_q[i] <= vx[(i + 1) % 3] - vx[i];
                        dy_q[i] <= vy[(i + 1) % 3] - vy[i];
                    end
                end
                else if (setup_q[1])
                begin
                    e_row <= e_init;
                    cur_y <= min_y_q;
                end
                else
                begin
                    e_pix <= e_row;
                    cur_x <= min_x_q;
                end
            end
            S_PIX:
            begin
                if (step && cur_x == max_x_q)
                begin
                    for (int i = 0; i < 3; i++)
                    begin
                        e_row[i] <= e_row[i] - dx_q[i];
                    end
                    cur_y <= cur_y + 1'b1;
                end
                else if (step)
                begin
                    for (int i = 0; i < 3; i++)
                    begin
                        e_pix[i] <= e_pix[i] + dy_q[i];
                    end
                    cur_x <= cur_x + 1'b1;
                end
            end
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/frag_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module frag_arbiter
#(
    parameter int N_PORTS = raster_pkg::N_WALKERS + 1
)
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire  [N_PORTS-1:0]    in_valid,
    input  wire raster_pkg::bus_s in_data [N_PORTS],
    output logic [N_PORTS-1:0]    in_ready,
    output logic                  out_valid,
    output raster_pkg::bus_s      out,
    input  wire                   out_ready
);

    localparam int IDX_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

    logic [IDX_W-1:0]             ptr_q;
    logic [IDX_W-1:0]             grant_q;
    logic                         lock_q;
    logic [IDX_W-1:0]             pick;
    logic [IDX_W-1:0]             grant;
    logic                         found;
    logic                         xfer;
    logic [raster_pkg::CNT_W-1:0] count_q;

    // First valid port at or after the pointer
    always_comb
    begin
        int unsigned idx;
        found = 1'b0;
        pick  = ptr_q;
        for (int k = 0; k < N_PORTS; k++)
        begin
            idx = (int'(ptr_q) + k) % N_PORTS;
            if (!found && in_valid[idx])
            begin
                found = 1'b1;
                pick  = IDX_W'(idx);
            end
        end
    end

    assign grant     = lock_q ? grant_q : pick;
    assign out_valid = in_valid[grant];
    assign xfer      = out_valid && out_ready;

    always_comb
    begin
        for (int i = 0; i < N_PORTS; i++)
        begin
            in_ready[i] = out_ready && (grant == IDX_W'(i));
        end
    end

    always_comb
    begin
        out = in_data[grant];
        if (out.is_marker)
            out.word.mark.count = count_q;
    end

    //////////////////////////////////////////////////////////////////////
    // Grant lock, rotation and frame count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ptr_q   <= '0;
            grant_q <= '0;
            lock_q  <= 1'b0;
            count_q <= '0;
        end
        else if (xfer)
        begin
            lock_q <= 1'b0;
            ptr_q  <= (grant == IDX_W'(N_PORTS - 1)) ? '0 : grant + 1'b1;
            if (out.is_marker)
                count_q <= '0;
            else
                count_q <= count_q + 1'b1;
        end
        else if (out_valid)
        begin
            // Stalled by the sink
            lock_q  <= 1'b1;
            grant_q <= grant;
        end
    end

endmodule

`default_nettype wire

/* design/raster_pkg.sv */
`default_nettype none

package raster_pkg;

    //////////////////////////////////////////////////////////////////////
    // Screen geometry and datapath widths
    //////////////////////////////////////////////////////////////////////

    localparam int COL_LEN   = 10;
    localparam int LINE_LEN  = 9;
    localparam int EDGE_W    = 24;
    localparam int N_WALKERS = 2;

    localparam int TAG_W = 4;
    localparam int Z_W   = 16;
    localparam int CNT_W = 16;

    //////////////////////////////////////////////////////////////////////
    // Command side
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [COL_LEN-1:0]  x;
        logic [LINE_LEN-1:0] y;
    } vertex_s;

    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } color_s;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        vertex_s          v1;
        vertex_s          v2;
        vertex_s          v3;
        color_s           color;
        logic [Z_W-1:0]   z;
    } tri_s;

    // On a flush only tri_data.tag matters, it names the frame
    typedef struct packed {
        logic is_flush;
        tri_s tri_data;
    } cmd_s;

    //////////////////////////////////////////////////////////////////////
    // Output bus
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [LINE_LEN-1:0] y;
        logic [COL_LEN-1:0]  x;
        color_s              color;
        logic [Z_W-1:0]      z;
    } frag_s;

    typedef struct packed {
        logic [TAG_W-1:0]                      frame;
        logic [CNT_W-1:0]                      count;
        logic [$bits(frag_s)-TAG_W-CNT_W-1:0] pad;
    } mark_s;

    typedef union packed {
        frag_s frag;
        mark_s mark;
    } bus_word_u;

    typedef struct packed {
        logic      is_marker;
        bus_word_u word;
    } bus_s;

endpackage

`default_nettype wire

/* design/raster_top.sv */
`timescale 1ns/100ps
`default_nettype none

module raster_top
#(
    parameter int N_WALKERS = raster_pkg::N_WALKERS
)
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cmd_valid,
    input  wire raster_pkg::cmd_s cmd,
    output logic                  cmd_ready,
    output logic                  out_valid,
    output raster_pkg::bus_s      out,
    input  wire                   out_ready
);

    wire [N_WALKERS-1:0]   tri_valid;
    wire raster_pkg::tri_s tri_data;
    wire [N_WALKERS-1:0]   tri_ready;

    // Walkers on the low ports, markers on the last one
    wire [N_WALKERS:0]     arb_valid;
    wire raster_pkg::bus_s arb_data [N_WALKERS+1];
    wire [N_WALKERS:0]     arb_ready;

    tri_dispatch #(
        .N_WALKERS (N_WALKERS)
    ) u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_ready  (cmd_ready),
        .tri_valid  (tri_valid),
        .tri_data   (tri_data),
        .tri_ready  (tri_ready),
        .mark_valid (arb_valid[N_WALKERS]),
        .mark       (arb_data[N_WALKERS]),
        .mark_ready (arb_ready[N_WALKERS])
    );

    generate
        for (genvar i = 0; i < N_WALKERS; i++)
        begin : g_walker
            edge_walker u_walker (
                .clk        (clk),
                .rst_n      (rst_n),
                .tri_valid  (tri_valid[i]),
                .tri_data   (tri_data),
                .tri_ready  (tri_ready[i]),
                .frag_valid (arb_valid[i]),
                .frag       (arb_data[i]),
                .frag_ready (arb_ready[i])
            );
        end
    endgenerate

    frag_arbiter #(
        .N_PORTS (N_WALKERS + 1)
    ) u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (arb_valid),
        .in_data   (arb_data),
        .in_ready  (arb_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* design/tri_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module tri_dispatch
#(
    parameter int N_WALKERS = raster_pkg::N_WALKERS
)
(
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   cmd_valid,
    input  wire raster_pkg::cmd_s cmd,
    output logic                  cmd_ready,
    output logic [N_WALKERS-1:0]  tri_valid,
    output raster_pkg::tri_s      tri_data,
    input  wire  [N_WALKERS-1:0]  tri_ready,
    output logic                  mark_valid,
    output raster_pkg::bus_s      mark,
    input  wire                   mark_ready
);

    logic [N_WALKERS-1:0] pick;
    logic                 any_idle;
    logic                 all_idle;
    logic                 is_flush;
    logic                 is_tri;
    logic                 mark_pend_q;

    // Lowest-numbered idle walker wins
    always_comb
    begin
        pick = '0;
        for (int i = N_WALKERS - 1; i >= 0; i--)
        begin
            if (tri_ready[i])
            begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    assign any_idle = |tri_ready;
    assign all_idle = &tri_ready;
    assign is_flush = cmd_valid && cmd.is_flush;
    assign is_tri   = cmd_valid && !cmd.is_flush && !mark_pend_q;

    assign tri_valid = is_tri ? pick : '0;
    assign tri_data  = cmd.tri_data;

    // The flush leaves together with its marker
    always_comb
    begin
        if (mark_pend_q)
            cmd_ready = mark_ready;
        else if (is_flush)
            cmd_ready = 1'b0;
        else
            cmd_ready = any_idle;
    end

    //////////////////////////////////////////////////////////////////////
    // End-of-frame marker
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            mark_pend_q <= 1'b0;
        else if (mark_pend_q)
        begin
            if (mark_ready)
                mark_pend_q <= 1'b0;
        end
        else if (is_flush && all_idle)
            mark_pend_q <= 1'b1;
    end

    assign mark_valid = mark_pend_q;

    // Count is filled in by the arbiter
    always_comb
    begin
        mark                 = '0;
        mark.is_marker       = 1'b1;
        mark.word.mark.frame = cmd.tri_data.tag;
    end

endmodule

`default_nettype wire

/* project.f */
design/raster_pkg.sv
design/edge_walker.sv
design/tri_dispatch.sv
design/frag_arbiter.sv
design/raster_top.sv
verif/raster_chk.sv
verif/raster_tb.sv

/* verif/raster_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module raster_chk
(
    input wire                   clk,
    input wire                   rst_n,
    input wire                   cmd_ready,
    input wire                   out_valid,
    input wire raster_pkg::bus_s out,
    input wire                   out_ready
);

    // Number of assertion failures so far
    int fail_cnt = 0;

    // A stalled beat holds until it is taken
    property stall_stable;
        @(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out);
    endproperty

    a_stall_stable: assert property (stall_stable)
        else
        begin
            fail_cnt++;
            $error("out changed while stalled by out_ready");
        end

    a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> cmd_ready)
        else
        begin
            fail_cnt++;
            $error("cmd_ready low when reset was released");
        end

    a_idle_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else
        begin
            fail_cnt++;
            $error("out_valid high during reset");
        end

endmodule

bind raster_top raster_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_ready (cmd_ready),
    .out_valid (out_valid),
    .out       (out),
    .out_ready (out_ready)
);

`default_nettype wire

/* verif/raster_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module raster_tb;

    localparam int CLK_HALF    = 50;
    localparam int CMD_LIMIT   = 5000;
    localparam int DRAIN_LIMIT = 20000;

    logic             clk;
    logic             rst_n;
    logic             cmd_valid;
    raster_pkg::cmd_s cmd;
    logic             cmd_ready;
    logic             out_valid;
    raster_pkg::bus_s out;
    logic             out_ready;

    // Commands in file order, triangles and flushes also kept apart
    raster_pkg::cmd_s cmds [$];
    raster_pkg::tri_s tris [$];
    int               exp_cnt [$];
    int               rx_cnt [$];
    int               flush_frame [$];
    int               tris_before [$];
    int               tri_of_tag [16];
    bit               seen [int];

    int fail_count;
    int exp_total;
    int rx_total;
    int frame_frags;
    int mark_rx;
    int last_idx;
    bit interleaved;

    raster_top #(
        .N_WALKERS (raster_pkg::N_WALKERS)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .out_valid (out_valid),
        .out       (out),
        .out_ready (out_ready)
    );

    always #CLK_HALF clk = ~clk;

    // Sink back-pressure
    initial
    begin
        out_ready = 1'b0;
        void'($urandom(58));
        forever
        begin
            @(negedge clk);
            out_ready = ($urandom % 4) != 0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Failure reporting
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string what);
        fail_count++;
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
        begin
            fail_count++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "run stopped");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference coverage
    //////////////////////////////////////////////////////////////////////

    // Twice the signed area of a, b, p
    function automatic int orient(int ax, int ay, int bx, int by, int px, int py);
        return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
    endfunction

    // Screen y grows downwards, so a counter-clockwise triangle has negative orient
    function automatic bit frag_covered(raster_pkg::tri_s t, int px, int py);
        int x [3];
        int y [3];
        x[0] = t.v1.x;
        y[0] = t.v1.y;
        x[1] = t.v2.x;
        y[1] = t.v2.y;
        x[2] = t.v3.x;
        y[2] = t.v3.y;
        if (orient(x[0], y[0], x[1], y[1], x[2], y[2]) >= 0)
            return 1'b0;
        for (int i = 0; i < 3; i++)
        begin
            if (orient(x[i], y[i], x[(i + 1) % 3], y[(i + 1) % 3], px, py) > 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic int min3(int a, int b, int c);
        int m;
        m = a;
        if (b < m)
            m = b;
        if (c < m)
            m = c;
        return m;
    endfunction

    function automatic int max3(int a, int b, int c);
        int m;
        m = a;
        if (b > m)
            m = b;
        if (c > m)
            m = c;
        return m;
    endfunction

    function automatic int coverage_size(raster_pkg::tri_s t);
        int n;
        n = 0;
        for (int y = min3(t.v1.y, t.v2.y, t.v3.y); y <= max3(t.v1.y, t.v2.y, t.v3.y); y++)
        begin
            for (int x = min3(t.v1.x, t.v2.x, t.v3.x); x <= max3(t.v1.x, t.v2.x, t.v3.x); x++)
            begin
                if (frag_covered(t, x, y))
                    n++;
            end
        end
        return n;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Command file and driver
    //////////////////////////////////////////////////////////////////////

    task automatic read_commands();
        int               fd;
        int               ch;
        int               n;
        int               f [12];
        raster_pkg::cmd_s c;
        fd = $fopen("verif/raster_testdata.txt", "r");
        if (fd == 0)
            abort_run("cannot open verif/raster_testdata.txt");
        ch = $fgetc(fd);
        while (ch != -1)
        begin
            c = '0;
            if (ch == "#")
            begin
                while (ch != "\n" && ch != -1)
                    ch = $fgetc(fd);
            end
            else if (ch == "T")
            begin
                n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d %d", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
                if (n != 12)
                    abort_run("malformed triangle line in the data file");
                if (tri_of_tag[f[0]] != -1)
                    abort_run("triangle tag used twice in the data file");
                c.tri_data.tag     = f[0];
                c.tri_data.v1.x    = f[1];
                c.tri_data.v1.y    = f[2];
                c.tri_data.v2.x    = f[3];
                c.tri_data.v2.y    = f[4];
                c.tri_data.v3.x    = f[5];
                c.tri_data.v3.y    = f[6];
                c.tri_data.color.r = f[7];
                c.tri_data.color.g = f[8];
                c.tri_data.color.b = f[9];
                c.tri_data.z       = f[10];
                compare_value($sformatf("coverage size of tag %0d", f[0]),
                              coverage_size(c.tri_data), f[11]);
                tri_of_tag[f[0]] = tris.size();
                tris.push_back(c.tri_data);
                exp_cnt.push_back(f[11]);
                rx_cnt.push_back(0);
                exp_total += f[11];
                cmds.push_back(c);
            end
            else if (ch == "F")
            begin
                n = $fscanf(fd, "%d", f[0]);
                if (n != 1)
                    abort_run("malformed flush line in the data file");
                c.is_flush     = 1'b1;
                c.tri_data.tag = f[0];
                flush_frame.push_back(f[0]);
                tris_before.push_back(tris.size());
                cmds.push_back(c);
            end
            else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t")
                abort_run("unexpected character in the data file");
            ch = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic send_command(input raster_pkg::cmd_s c);
        int waited;
        bit taken;
        waited    = 0;
        taken     = 1'b0;
        cmd_valid = 1'b1;
        cmd       = c;
        while (!taken)
        begin
            @(posedge clk);
            if (cmd_ready)
                taken = 1'b1;
            else
            begin
                waited++;
                if (waited > CMD_LIMIT)
                    abort_run($sformatf("command with tag %0d was never accepted",
                                        c.tri_data.tag));
            end
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (rx_total != exp_total || mark_rx != flush_frame.size())
        begin
            @(negedge clk);
            waited++;
            if (waited > DRAIN_LIMIT)
                abort_run("timed out waiting for the output bus to drain");
        end
        // Room for stray beats to show up
        repeat (20) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////////////////////////

    task automatic take_beat(input raster_pkg::bus_s b);
        raster_pkg::frag_s f;
        int                k;
        int                key;
        if (b.is_marker)
        begin
            if (mark_rx >= flush_frame.size())
                abort_run("marker arrived without a pending flush");
            compare_value("out.word.mark.frame", b.word.mark.frame, flush_frame[mark_rx]);
            compare_value("out.word.mark.count", b.word.mark.count, frame_frags);
            compare_value("out.word.mark.pad", b.word.mark.pad, 0);
            // Earlier triangles must be complete
            for (int i = 0; i < tris_before[mark_rx]; i++)
                compare_value($sformatf("fragment count of tag %0d", tris[i].tag),
                              rx_cnt[i], exp_cnt[i]);
            frame_frags = 0;
            mark_rx++;
        end
        else
        begin
            f = b.word.frag;
            k = tri_of_tag[f.tag];
            if (k < 0)
                abort_run($sformatf("fragment with unknown tag %0d", f.tag));
            compare_value($sformatf("out.word.frag covered at x=%0d y=%0d", f.x, f.y),
                          frag_covered(tris[k], f.x, f.y), 1);
            key = int'({f.tag, f.y, f.x});
            compare_value("out.word.frag repeated", seen.exists(key), 0);
            seen[key] = 1'b1;
            compare_value("out.word.frag.color", f.color, tris[k].color);
            compare_value("out.word.frag.z", f.z, tris[k].z);
            if (last_idx >= 0 && last_idx != k && rx_cnt[last_idx] < exp_cnt[last_idx])
                interleaved = 1'b1;
            last_idx = k;
            rx_cnt[k]++;
            frame_frags++;
            rx_total++;
        end
    endtask

    always @(posedge clk)
    begin
        if (rst_n && out_valid && out_ready)
            take_beat(out);
    end

    always @(negedge clk)
    begin
        if (dut.u_chk.fail_cnt != 0)
            abort_run("an assertion in the bound checker failed");
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        cmd_valid   = 1'b0;
        cmd         = '0;
        fail_count  = 0;
        exp_total   = 0;
        rx_total    = 0;
        frame_frags = 0;
        mark_rx     = 0;
        last_idx    = -1;
        interleaved = 1'b0;
        for (int i = 0; i < 16; i++)
            tri_of_tag[i] = -1;

        read_commands();

        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Back to back, so both walkers get work
        for (int i = 0; i < cmds.size(); i++)
            send_command(cmds[i]);

        wait_drain();

        compare_value("tag interleaving", interleaved, 1);

        if (fail_count == 0 && dut.u_chk.fail_cnt == 0)
        begin
            $display("Test OK");
            $finish;
        end
        else
        begin
            $display("Test FAILED");
            $fatal(1, "run stopped");
        end
    end

endmodule

`default_nettype wire

/* verif/raster_testdata.txt */
# Columns: T tag x1 y1 x2 y2 x3 y3 r g b z count
#          F frame
# All values decimal, count is the number of covered pixels
#
# Frame 1: two large triangles back to back, then rejected ones
T 1 10 10 10 20 20 10 63 0 12 4096 66
T 2 48 12 40 20 48 20 5 40 33 1000 45
T 3 100 100 104 108 108 100 17 17 60 65535 41
# clockwise
T 4 200 50 206 50 200 56 1 2 3 77 0
# collinear
T 5 300 300 305 305 310 310 9 9 9 88 0
F 1
#
# Frame 2: screen corners and tiny triangles
T 6 620 460 620 475 635 460 0 63 0 12345 136
T 7 12 0 0 12 12 12 31 32 33 0 91
T 8 320 240 320 241 321 240 63 63 63 2 3
T 9 502 100 500 102 502 102 44 11 22 40000 6
F 2
#
# Frame 3 is empty
F 3
#
# Frame 4
T 10 200 200 204 208 208 200 7 8 9 300 41
T 11 400 300 400 305 405 300 50 25 12 54321 21
F 4
